// File: ahb_sub_decoder.f
rtl/ahb_pkg.sv
rtl/addr_map_pkg.sv
rtl/ahb_cmd_if.sv
rtl/addr_decoder.sv
rtl/cmd_hold.sv
rtl/phase_sequencer.sv
rtl/ahb_sub_decoder.sv
verification/tb_clock_gen.sv
verification/tb_ahb_sub_decoder.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := tb_ahb_sub_decoder
FILELIST  := ahb_sub_decoder.f
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/tb_ahb_sub_decoder.sv
// testbench top that drives the master port and models six slaves to check routing and stalls
`default_nettype none

module tb_ahb_sub_decoder
  import ahb_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_SLAVES      = 6;
  localparam int STALL_MAX       = 3;
  localparam int MAX_WAIT        = 2 * STALL_MAX;
  localparam int NUM_RANDOM      = 40;
  localparam int NUM_XFERS       = 4 * NUM_SLAVES + 4 + NUM_RANDOM;
  localparam int WATCHDOG_CYCLES = NUM_XFERS * (MAX_WAIT + 3) + 20;

  localparam haddr_t TB_BASE [NUM_SLAVES] = '{32'h4020_0000, 32'h4030_0000, 32'h5000_0000,
    32'h6000_0000, 32'h7000_0000, 32'h7800_0000};
  localparam haddr_t TB_LIMIT [NUM_SLAVES] = '{32'h4020_0FFF, 32'h403F_FFFF, 32'h5004_FFFF,
    32'h6004_FFFF, 32'h77FF_FFFF, 32'h7FFF_FFFF};

  typedef struct packed {
    int     slave;
    haddr_t addr;
    logic   write;
    hsize_t size;
    hdata_t wdata;
  } xfer_t;

  logic                    hclk, hresetn;
  haddr_t                  m_haddr, s_haddr;
  htrans_e                 m_htrans, s_htrans;
  logic                    m_hwrite, s_hwrite, m_hready;
  hsize_t                  m_hsize, s_hsize;
  hdata_t                  m_hwdata, m_hrdata, s_hwdata;
  hresp_e                  m_hresp;
  logic [NUM_SLAVES-1:0]   s_hsel, s_hready;
  hdata_t [NUM_SLAVES-1:0] s_hrdata;
  hresp_e [NUM_SLAVES-1:0] s_hresp;

  integer                seed = 32'h6c45;
  integer                rnd;
  int                    sel;
  haddr_t                base;
  hsize_t                size_pick;
  xfer_t                 expect_q [$];
  string                 test_name = "reset";
  int                    value_errs = 0;
  int                    other_errs = 0;
  int                    wait_cnt [NUM_SLAVES] = '{default: 0};
  haddr_t                dp_addr [NUM_SLAVES] = '{default: '0};
  logic                  wr_due = 1'b0;
  int                    wr_slave = 0;
  hdata_t                wr_data;
  logic                  stall_seen = 1'b0;
  logic [NUM_SLAVES-1:0] held_hsel;
  haddr_t                held_addr;

  tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(5)) u_clock_gen (
    .hclk    (hclk),
    .hresetn (hresetn)
  );

  ahb_sub_decoder #(.NUM_SLAVES(NUM_SLAVES)) dut (.*);

  // expected slave for an address or -1 when the transfer goes nowhere
  function automatic int ref_route(input haddr_t addr, input htrans_e trans,
                                   output hdata_t rdata, output hresp_e resp);
    int hit;
    hit   = -1;
    rdata = '0;
    resp  = OKAY;
    if (trans == NONSEQ || trans == SEQ) begin
      for (int i = 0; i < NUM_SLAVES; i++) begin
        if (hit < 0 && addr >= TB_BASE[i] && addr <= TB_LIMIT[i]) hit = i;
      end
    end
    if (hit >= 0) begin
      rdata = addr ^ haddr_t'(hit);
      resp  = (addr[3:2] == 2'b11) ? ERROR : OKAY;
    end
    return hit;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error %s: %s expected %h, actual %h at %0t",
             test_name, what, expected, actual, $time);
    value_errs++;
  endtask

  task automatic wait_hready();
    @(negedge hclk);
    while (!m_hready) @(negedge hclk);
  endtask

  // one complete transfer with its address phase and data phase
  task automatic run_xfer(input haddr_t addr, input htrans_e trans, input logic write,
                          input hsize_t size, input hdata_t wdata);
    int     exp_slave;
    hdata_t exp_rdata;
    hresp_e exp_resp;
    xfer_t  item;
    exp_slave = ref_route(addr, trans, exp_rdata, exp_resp);
    if (exp_slave >= 0) begin
      item = '{exp_slave, addr, write, size, wdata};
      expect_q.push_back(item);
    end
    m_haddr  = addr;
    m_htrans = trans;
    m_hwrite = write;
    m_hsize  = size;
    wait_hready();
    @(posedge hclk);
    #2;
    m_htrans = IDLE;
    m_hwdata = wdata;
    if (exp_slave < 0) begin
      // nothing routed so the data phase ends at once
      @(negedge hclk);
      if (m_hready !== 1'b1) report_mismatch("hready", 32'd1, 32'(m_hready));
    end else begin
      wait_hready();
    end
    if (exp_slave >= 0 && !write && m_hrdata !== exp_rdata) begin
      report_mismatch("hrdata", exp_rdata, m_hrdata);
    end
    if (m_hresp !== exp_resp) report_mismatch("hresp", 32'(exp_resp), 32'(m_hresp));
    @(posedge hclk);
    #2;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slave models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge hclk) begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (s_hsel[i] && s_hready[i]) dp_addr[i] = s_haddr;
    end
  end

  // one ready cycle then up to STALL_MAX stalled ones
  always @(posedge hclk) begin
    #2;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (wait_cnt[i] == 0) begin
        s_hready[i] = 1'b1;
        wait_cnt[i] = $unsigned($random(seed)) % (STALL_MAX + 1);
      end else begin
        s_hready[i] = 1'b0;
        wait_cnt[i] = wait_cnt[i] - 1;
      end
      s_hrdata[i] = dp_addr[i] ^ hdata_t'(i);
      s_hresp[i]  = (dp_addr[i][3:2] == 2'b11) ? ERROR : OKAY;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // acceptance log against expected transfers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge hclk) begin : compare_accept
    xfer_t want;
    if (hresetn) begin
      if (stall_seen && (s_hsel !== held_hsel || s_haddr !== held_addr)) begin
        report_mismatch("stalled haddr", held_addr, s_haddr);
      end
      if (wr_due && s_hready[wr_slave]) begin
        if (s_hwdata !== wr_data) report_mismatch("hwdata", wr_data, s_hwdata);
        wr_due = 1'b0;
      end
      for (int i = 0; i < NUM_SLAVES; i++) begin
        if (s_hsel[i] && s_hready[i]) begin
          if (expect_q.size() == 0) begin
            $display("slave %0d accepted address %h with no transfer outstanding", i, s_haddr);
            other_errs++;
          end else begin
            want = expect_q.pop_front();
            if (want.slave != i) report_mismatch("slave number", want.slave, i);
            if (want.addr !== s_haddr) report_mismatch("haddr", want.addr, s_haddr);
            if (want.write !== s_hwrite) report_mismatch("hwrite", 32'(want.write), 32'(s_hwrite));
            if (want.size !== s_hsize) report_mismatch("hsize", 32'(want.size), 32'(s_hsize));
            if (s_htrans !== NONSEQ) report_mismatch("htrans", 32'(NONSEQ), 32'(s_htrans));
            wr_due   = want.write;
            wr_slave = i;
            wr_data  = want.wdata;
          end
        end
      end
      stall_seen = |(s_hsel & ~s_hready);
      held_hsel  = s_hsel;
      held_addr  = s_haddr;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge hclk);
    $display("watchdog expired after %0d cycles, transfers did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    m_haddr  = '0;
    m_htrans = IDLE;
    m_hwrite = 1'b0;
    m_hsize  = 3'd2;
    m_hwdata = '0;
    s_hready = '1;
    s_hrdata = '0;
    for (int i = 0; i < NUM_SLAVES; i++) s_hresp[i] = OKAY;
    @(posedge hresetn);
    @(negedge hclk);
    if (s_hsel !== '0) report_mismatch("hsel", 32'd0, 32'(s_hsel));
    if (s_htrans !== IDLE) report_mismatch("htrans", 32'(IDLE), 32'(s_htrans));
    if (m_hready !== 1'b1) report_mismatch("hready", 32'd1, 32'(m_hready));
    @(posedge hclk);
    #2;

    test_name = "decode";
    for (int i = 0; i < NUM_SLAVES; i++) begin
      run_xfer(TB_BASE[i], NONSEQ, 1'b0, 3'd2, '0);
      run_xfer(TB_LIMIT[i], NONSEQ, 1'b0, 3'd2, '0);
      run_xfer(TB_BASE[i] - 1, NONSEQ, 1'b0, 3'd2, '0);
      run_xfer(TB_LIMIT[i] + 1, NONSEQ, 1'b0, 3'd2, '0);
    end

    test_name = "ignored";
    run_xfer(TB_BASE[2], IDLE, 1'b0, 3'd2, '0);
    run_xfer(TB_BASE[3] + 32'h10, BUSY, 1'b1, 3'd2, 32'h0bad_0001);
    run_xfer(32'h0000_1000, NONSEQ, 1'b0, 3'd2, '0);
    run_xfer(32'hF000_0000, SEQ, 1'b1, 3'd2, 32'h0bad_0002);

    // random slaves, offsets, sizes and directions with some unmapped picks
    test_name = "random";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      sel = $unsigned($random(seed)) % 8;
      rnd = $random(seed);
      if (sel < NUM_SLAVES) begin
        base = TB_BASE[sel];
      end else begin
        base = 32'h1000_0000;
      end
      size_pick = hsize_t'(rnd[15:14] % 3);
      run_xfer(base + (rnd & 32'h0FFC), rnd[12] ? SEQ : NONSEQ, rnd[13], size_pick,
               $random(seed));
    end

    test_name = "drain";
    repeat (2) @(posedge hclk);
    if (expect_q.size() != 0) begin
      $display("%0d expected transfers never reached a slave", expect_q.size());
      other_errs++;
    end
    $display("error count: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// clock and reset source instantiated by the testbench top, 20 ns hclk and a held-low hresetn
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic hclk,
  output logic hresetn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    hclk = 1'b0;
    forever #(HALF_PERIOD) hclk = ~hclk;
  end

  // release away from the clock edge
  initial begin
    hresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge hclk);
    #2;
    hresetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/ahb_sub_decoder.sv
// AHB-Lite sub-decoder top, fans one master port out to NUM_SLAVES address regions
`default_nettype none

module ahb_sub_decoder
  import ahb_pkg::*, addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = MAX_SLAVES
) (
  input  logic                    hclk,
  input  logic                    hresetn,
  // master side
  input  haddr_t                  m_haddr,
  input  htrans_e                 m_htrans,
  input  logic                    m_hwrite,
  input  hsize_t                  m_hsize,
  input  hdata_t                  m_hwdata,
  output logic                    m_hready,
  output hdata_t                  m_hrdata,
  output hresp_e                  m_hresp,
  // slave side
  output haddr_t                  s_haddr,
  output logic                    s_hwrite,
  output hsize_t                  s_hsize,
  output htrans_e                 s_htrans,
  output logic   [NUM_SLAVES-1:0] s_hsel,
  output hdata_t                  s_hwdata,
  input  logic   [NUM_SLAVES-1:0] s_hready,
  input  hdata_t [NUM_SLAVES-1:0] s_hrdata,
  input  hresp_e [NUM_SLAVES-1:0] s_hresp
);

  ahb_cmd_if dec_cmd ();
  ahb_cmd_if seq_cmd ();

  addr_decoder #(.NUM_SLAVES(NUM_SLAVES)) u_addr_decoder (
    .m_haddr  (m_haddr),
    .m_htrans (m_htrans),
    .m_hwrite (m_hwrite),
    .m_hsize  (m_hsize),
    .m_hready (m_hready),
    .src      (dec_cmd.src)
  );

  cmd_hold #(.NUM_SLAVES(NUM_SLAVES)) u_cmd_hold (
    .hclk    (hclk),
    .hresetn (hresetn),
    .dst     (dec_cmd.dst),
    .src     (seq_cmd.src)
  );

  phase_sequencer #(.NUM_SLAVES(NUM_SLAVES)) u_phase_sequencer (
    .hclk     (hclk),
    .hresetn  (hresetn),
    .m_hwdata (m_hwdata),
    .dst      (seq_cmd.dst),
    .s_hready (s_hready),
    .s_hrdata (s_hrdata),
    .s_hresp  (s_hresp),
    .s_haddr  (s_haddr),
    .s_hwrite (s_hwrite),
    .s_hsize  (s_hsize),
    .s_htrans (s_htrans),
    .s_hsel   (s_hsel),
    .s_hwdata (s_hwdata),
    .m_hready (m_hready),
    .m_hrdata (m_hrdata),
    .m_hresp  (m_hresp)
  );

endmodule

`default_nettype wire

// File: rtl/phase_sequencer.sv
// drives the slave address phase, tracks the data phase and returns the response
`default_nettype none

module phase_sequencer
  import ahb_pkg::*, addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = MAX_SLAVES
) (
  input  logic                            hclk,
  input  logic                            hresetn,
  input  hdata_t                          m_hwdata,
  ahb_cmd_if.dst                          dst,
  input  logic   [NUM_SLAVES-1:0]         s_hready,
  input  hdata_t [NUM_SLAVES-1:0]         s_hrdata,
  input  hresp_e [NUM_SLAVES-1:0]         s_hresp,
  output haddr_t                          s_haddr,
  output logic                            s_hwrite,
  output hsize_t                          s_hsize,
  output htrans_e                         s_htrans,
  output logic   [NUM_SLAVES-1:0]         s_hsel,
  output hdata_t                          s_hwdata,
  output logic                            m_hready,
  output hdata_t                          m_hrdata,
  output hresp_e                          m_hresp
);

  seq_state_e state;
  seq_state_e state_nxt;
  slave_idx_t act_slave;
  logic       in_data;
  logic       pipe_free;
  logic       cmd_go;

  assign in_data = (state == ST_DATA);

  // no data phase left in flight after this cycle
  assign pipe_free = !in_data || s_hready[act_slave];

  assign dst.ready = pipe_free && s_hready[dst.slave];
  assign cmd_go    = dst.valid && dst.ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_nxt = state;
    if (pipe_free) begin
      if (cmd_go) begin
        state_nxt = ST_DATA;
      end else if (dst.valid) begin
        state_nxt = ST_CMD;
      end else begin
        state_nxt = ST_IDLE;
      end
    end
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      state     <= ST_IDLE;
      act_slave <= '0;
    end else begin
      state <= state_nxt;
      if (cmd_go) begin
        act_slave <= dst.slave;
      end
    end
  end

  // slave address phase, shared bus plus one-hot select
  assign s_haddr  = dst.addr;
  assign s_hwrite = dst.write;
  assign s_hsize  = dst.size;
  assign s_htrans = dst.valid ? NONSEQ : IDLE;

  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      s_hsel[i] = dst.valid && (dst.slave == slave_idx_t'(i));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data phase muxing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign s_hwdata = in_data ? m_hwdata : '0;
  assign m_hrdata = in_data ? s_hrdata[act_slave] : '0;
  assign m_hresp  = in_data ? s_hresp[act_slave] : OKAY;

  // master stalls while a command is parked
  always_comb begin
    case (state)
      ST_IDLE: m_hready = 1'b1;
      ST_CMD:  m_hready = 1'b0;
      ST_DATA: m_hready = s_hready[act_slave];
      default: m_hready = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/cmd_hold.sv
// one-entry command register that passes a command straight on or parks it for a busy slave
`default_nettype none

module cmd_hold
  import ahb_pkg::*, addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = MAX_SLAVES
) (
  input  logic   hclk,
  input  logic   hresetn,
  ahb_cmd_if.dst dst,
  ahb_cmd_if.src src
);

  logic       full;
  logic       load;
  slave_idx_t held_slave;
  haddr_t     held_addr;
  logic       held_write;
  hsize_t     held_size;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output side with the held copy first
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign src.valid = full || dst.valid;
  assign src.slave = full ? held_slave : dst.slave;
  assign src.addr  = full ? held_addr  : dst.addr;
  assign src.write = full ? held_write : dst.write;
  assign src.size  = full ? held_size  : dst.size;

  assign dst.ready = !full || src.ready;

  // capture whatever arrives and cannot go out this cycle
  assign load = dst.valid && dst.ready && (full || !src.ready);

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (src.ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge hclk) begin
    if (load) begin
      held_slave <= dst.slave;
      held_addr  <= dst.addr;
      held_write <= dst.write;
      held_size  <= dst.size;
    end
  end

endmodule

`default_nettype wire

// File: rtl/addr_decoder.sv
// decodes the master address phase into a command naming the target slave
`default_nettype none

module addr_decoder
  import ahb_pkg::*, addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = MAX_SLAVES
) (
  input  haddr_t  m_haddr,
  input  htrans_e m_htrans,
  input  logic    m_hwrite,
  input  hsize_t  m_hsize,
  input  logic    m_hready,
  ahb_cmd_if.src  src
);

  logic       hit;
  slave_idx_t hit_idx;
  logic       active_trans;

  // walk down so the lowest matching region is the one left standing
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if ((m_haddr >= REGION_BASE[i]) && (m_haddr <= REGION_LIMIT[i])) begin
        hit     = 1'b1;
        hit_idx = slave_idx_t'(i);
      end
    end
  end

  // IDLE and BUSY carry nothing to route
  assign active_trans = (m_htrans == NONSEQ) || (m_htrans == SEQ);

  assign src.valid = hit && active_trans && m_hready;
  assign src.slave = hit_idx;
  assign src.addr  = m_haddr;
  assign src.write = m_hwrite;
  assign src.size  = m_hsize;

endmodule

`default_nettype wire

// File: rtl/ahb_cmd_if.sv
// address-phase command with valid/ready, links decoder, hold register and sequencer
`default_nettype none

interface ahb_cmd_if
  import ahb_pkg::*, addr_map_pkg::*;
();

  logic       valid;
  logic       ready;
  slave_idx_t slave;
  haddr_t     addr;
  logic       write;
  hsize_t     size;

  // producer side
  modport src (output valid, slave, addr, write, size, input ready);

  // consumer side
  modport dst (input valid, slave, addr, write, size, output ready);

endinterface

`default_nettype wire

// File: rtl/addr_map_pkg.sv
// slave address map of the sub-decoder, one inclusive region per slave port
`default_nettype none

package addr_map_pkg;
  import ahb_pkg::*;

  localparam int MAX_SLAVES = 6;

  typedef logic [2:0] slave_idx_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // region table, slave i owns entry i
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam haddr_t REGION_BASE [MAX_SLAVES] = '{
    32'h4020_0000,
    32'h4030_0000,
    32'h5000_0000,
    32'h6000_0000,
    32'h7000_0000,
    32'h7800_0000
  };

  // limits are inclusive
  localparam haddr_t REGION_LIMIT [MAX_SLAVES] = '{
    32'h4020_0FFF,
    32'h403F_FFFF,
    32'h5004_FFFF,
    32'h6004_FFFF,
    32'h77FF_FFFF,
    32'h7FFF_FFFF
  };

endpackage

`default_nettype wire

// File: rtl/ahb_pkg.sv
// AHB-Lite protocol types shared by the sub-decoder datapath and the testbench
`default_nettype none

package ahb_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int HADDR_W = 32;
  localparam int HDATA_W = 32;
  localparam int HSIZE_W = 3;

  typedef logic [HADDR_W-1:0] haddr_t;
  typedef logic [HDATA_W-1:0] hdata_t;
  typedef logic [HSIZE_W-1:0] hsize_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // protocol encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,
    SPLIT = 2'b11
  } hresp_e;

  // sequencer states
  // ST_CMD: command parked, waiting on the target slave
  // ST_DATA: data phase running on the active slave
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_CMD  = 2'b01,
    ST_DATA = 2'b10
  } seq_state_e;

endpackage

`default_nettype wire
